/* include/load_defs.svh */
`ifndef LOAD_DEFS_SVH
`define LOAD_DEFS_SVH

// ************************************************
// Data path widths
// ************************************************
`define LOAD_LINE_WIDTH 512
`define LOAD_ADDR_WIDTH 48
`define LOAD_LEN_WIDTH 32

// ************************************************
// Prefetch FIFO
// ************************************************
`define LOAD_LOG2_PREFETCH 4
`define LOAD_PREFETCH_DEPTH (1 << `LOAD_LOG2_PREFETCH)

// Index offsets summed onto the base address
`define LOAD_NUM_OFFSETS 3

// ************************************************
// DMA burst codes
// ************************************************
`define LOAD_BURST_WIDTH 2
`define LOAD_BURST_1 2'd0
`define LOAD_BURST_2 2'd1
`define LOAD_BURST_4 2'd3

`endif

/* hdl/load_pkg.sv */
`include "load_defs.svh"

package load_pkg;

    typedef logic [`LOAD_LINE_WIDTH-1:0] line_t;
    typedef logic [`LOAD_ADDR_WIDTH-1:0] line_addr_t;
    typedef logic [`LOAD_LEN_WIDTH-1:0] line_count_t;
    typedef logic [`LOAD_BURST_WIDTH-1:0] burst_t;

    // Operation setup, sampled when a load starts
    typedef struct packed {
        line_addr_t  base_addr;
        line_count_t offset0;
        line_count_t offset1;
        line_count_t offset2;
        line_count_t length;
        logic        multiline;
        logic        trigger_dma;
    } load_cfg_t;

    // Read command for the DMA engine
    typedef struct packed {
        line_addr_t  addr;
        line_count_t length;
        logic        multiline;
    } dma_cmd_t;

    typedef enum logic [2:0] {
        REQ_IDLE,
        REQ_ACCUMULATE,
        REQ_DMA_TRIGGER,
        REQ_READ,
        REQ_DONE
    } request_state_t;

    typedef enum logic [1:0] {
        RCV_IDLE,
        RCV_READ,
        RCV_DONE
    } receive_state_t;

endpackage

/* hdl/prefetch_fifo.sv */
`timescale 1ns/1ps
`include "load_defs.svh"

module prefetch_fifo
(
    input  logic                          clk,
    input  logic                          internal_reset,
    input  logic                          we,
    input  load_pkg::line_t               wdata,
    input  logic                          re,
    output logic                          rvalid,
    output load_pkg::line_t               rdata,
    output logic                          empty,
    output logic [`LOAD_LOG2_PREFETCH:0]  count
);
    import load_pkg::*;

    line_t mem [`LOAD_PREFETCH_DEPTH];
    logic [`LOAD_LOG2_PREFETCH-1:0] wptr;
    logic [`LOAD_LOG2_PREFETCH-1:0] rptr;
    logic full;
    logic do_write;
    logic do_read;

    // Depth is a power of two, so the count MSB marks full
    assign full = count[`LOAD_LOG2_PREFETCH];
    assign empty = (count == '0);
    assign do_write = we && !full;
    assign do_read = re && !empty;

    always_ff @(posedge clk)
    begin
        if (internal_reset)
        begin
            wptr <= '0;
            rptr <= '0;
            count <= '0;
            rvalid <= 1'b0;
        end
        else
        begin
            rvalid <= do_read;
            if (do_write)
            begin
                wptr <= wptr + 1'b1;
            end
            if (do_read)
            begin
                rptr <= rptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and registered read port
    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            mem[wptr] <= wdata;
        end
        if (do_read)
        begin
            rdata <= mem[rptr];
        end
    end

endmodule

/* hdl/load_request_ctrl.sv */
`timescale 1ns/1ps
`include "load_defs.svh"

module load_request_ctrl
(
    input  logic                          clk,
    input  logic                          internal_reset,
    input  logic                          req_start,
    input  load_pkg::load_cfg_t           cfg,
    input  logic                          dma_idle,
    input  logic                          dma_active,
    output logic                          dma_cmd_valid,
    output load_pkg::dma_cmd_t            dma_cmd,
    output logic                          line_req_valid,
    output load_pkg::burst_t              line_req_burst,
    input  logic                          rx_valid,
    input  load_pkg::line_t               rx_data,
    output logic                          fifo_we,
    output load_pkg::line_t               fifo_wdata,
    input  logic [`LOAD_LOG2_PREFETCH:0]  fifo_count
);
    import load_pkg::*;

    localparam int IDX_W = $clog2(`LOAD_NUM_OFFSETS);

    request_state_t state;
    logic [IDX_W-1:0] offset_idx;
    line_count_t offsets [`LOAD_NUM_OFFSETS];
    line_addr_t line_addr;
    line_count_t length;
    logic multiline;
    logic trigger_dma;

    // ************************************************
    // Credit accounting
    // ************************************************
    line_count_t requested;
    line_count_t received;
    line_count_t in_flight;
    line_count_t credit;

    assign in_flight = requested - received;
    // A line in the write stage is neither in flight nor counted by the FIFO yet
    assign credit = line_count_t'(`LOAD_PREFETCH_DEPTH) - line_count_t'(fifo_count)
                    - in_flight - line_count_t'(fifo_we);

    // Burst choice for the next request
    logic burst_ok;
    burst_t burst_code;
    line_count_t burst_lines;
    logic issue;

    always_comb
    begin
        burst_ok = 1'b1;
        burst_code = `LOAD_BURST_1;
        burst_lines = line_count_t'(1);
        if (multiline && (requested + line_count_t'(4) < length))
        begin
            burst_code = `LOAD_BURST_4;
            burst_lines = line_count_t'(4);
        end
        else if (multiline && (requested + line_count_t'(2) < length))
        begin
            burst_code = `LOAD_BURST_2;
            burst_lines = line_count_t'(2);
        end
        else if (!(requested < length))
        begin
            burst_ok = 1'b0;
        end
    end

    // Hold the burst back until the FIFO can take all of it
    assign issue = (state == REQ_READ) && dma_active && burst_ok && (credit >= burst_lines);

    // ************************************************
    // Request FSM
    // ************************************************
    always_ff @(posedge clk)
    begin
        if (internal_reset)
        begin
            state <= REQ_IDLE;
            offset_idx <= '0;
            requested <= '0;
            received <= '0;
            dma_cmd_valid <= 1'b0;
            line_req_valid <= 1'b0;
            fifo_we <= 1'b0;
        end
        else
        begin
            dma_cmd_valid <= 1'b0;
            line_req_valid <= 1'b0;
            fifo_we <= rx_valid;
            if (rx_valid)
            begin
                received <= received + 1'b1;
            end
            case (state)
                REQ_IDLE:
                begin
                    if (req_start)
                    begin
                        offset_idx <= '0;
                        requested <= '0;
                        received <= '0;
                        state <= REQ_ACCUMULATE;
                    end
                end
                REQ_ACCUMULATE:
                begin
                    offset_idx <= offset_idx + 1'b1;
                    if (offset_idx == IDX_W'(`LOAD_NUM_OFFSETS - 1))
                    begin
                        state <= trigger_dma ? REQ_DMA_TRIGGER : REQ_READ;
                    end
                end
                REQ_DMA_TRIGGER:
                begin
                    if (dma_idle)
                    begin
                        dma_cmd_valid <= 1'b1;
                        state <= REQ_READ;
                    end
                end
                REQ_READ:
                begin
                    if (issue)
                    begin
                        line_req_valid <= 1'b1;
                        requested <= requested + burst_lines;
                    end
                    if (requested == length)
                    begin
                        state <= REQ_DONE;
                    end
                end
                default:
                begin
                    state <= REQ_IDLE;
                end
            endcase
        end
    end

    // Operation setup, address sum and outgoing payloads
    always_ff @(posedge clk)
    begin
        if (state == REQ_IDLE && req_start)
        begin
            line_addr <= cfg.base_addr;
            offsets[0] <= cfg.offset0;
            offsets[1] <= cfg.offset1;
            offsets[2] <= cfg.offset2;
            length <= cfg.length;
            multiline <= cfg.multiline;
            trigger_dma <= cfg.trigger_dma;
        end
        if (state == REQ_ACCUMULATE)
        begin
            line_addr <= line_addr + line_addr_t'(offsets[offset_idx]);
        end
        if (state == REQ_DMA_TRIGGER && dma_idle)
        begin
            dma_cmd.addr <= line_addr;
            dma_cmd.length <= length;
            dma_cmd.multiline <= multiline;
        end
        if (issue)
        begin
            line_req_burst <= burst_code;
        end
        fifo_wdata <= rx_data;
    end

endmodule

/* hdl/load_receive_ctrl.sv */
`timescale 1ns/1ps
`include "load_defs.svh"

module load_receive_ctrl
(
    input  logic                   clk,
    input  logic                   internal_reset,
    input  logic                   op_start,
    input  load_pkg::line_count_t  cfg_length,
    output logic                   req_start,
    input  logic                   fifo_rvalid,
    input  load_pkg::line_t        fifo_rdata,
    input  logic                   fifo_empty,
    output logic                   fifo_re,
    input  logic                   out_almost_full,
    output logic                   out_valid,
    output load_pkg::line_t        out_data,
    output logic                   op_done
);
    import load_pkg::*;

    receive_state_t state;
    line_count_t length;
    line_count_t forwarded;

    // Drain the FIFO whenever the consumer has room
    assign fifo_re = !fifo_empty && !out_almost_full;

    always_ff @(posedge clk)
    begin
        if (internal_reset)
        begin
            state <= RCV_IDLE;
            forwarded <= '0;
            req_start <= 1'b0;
            out_valid <= 1'b0;
            op_done <= 1'b0;
        end
        else
        begin
            req_start <= 1'b0;
            out_valid <= 1'b0;
            op_done <= 1'b0;
            case (state)
                RCV_IDLE:
                begin
                    if (op_start)
                    begin
                        forwarded <= '0;
                        // Empty loads skip the requester entirely
                        if (cfg_length == '0)
                        begin
                            state <= RCV_DONE;
                        end
                        else
                        begin
                            req_start <= 1'b1;
                            state <= RCV_READ;
                        end
                    end
                end
                RCV_READ:
                begin
                    if (fifo_rvalid)
                    begin
                        out_valid <= 1'b1;
                        forwarded <= forwarded + 1'b1;
                        if (forwarded == length - 1'b1)
                        begin
                            state <= RCV_DONE;
                        end
                    end
                end
                default:
                begin
                    op_done <= 1'b1;
                    state <= RCV_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == RCV_IDLE && op_start)
        begin
            length <= cfg_length;
        end
        out_data <= fifo_rdata;
    end

endmodule

/* hdl/load_unit.sv */
`timescale 1ns/1ps
`include "load_defs.svh"

module load_unit
(
    input  logic                 clk,
    input  logic                 internal_reset,
    input  logic                 op_start,
    input  load_pkg::load_cfg_t  cfg,
    output logic                 op_done,
    input  logic                 dma_idle,
    input  logic                 dma_active,
    output logic                 dma_cmd_valid,
    output load_pkg::dma_cmd_t   dma_cmd,
    output logic                 line_req_valid,
    output load_pkg::burst_t     line_req_burst,
    input  logic                 rx_valid,
    input  load_pkg::line_t      rx_data,
    input  logic                 out_almost_full,
    output logic                 out_valid,
    output load_pkg::line_t      out_data
);
    import load_pkg::*;

    logic req_start;
    logic fifo_we;
    line_t fifo_wdata;
    logic fifo_re;
    logic fifo_rvalid;
    line_t fifo_rdata;
    logic fifo_empty;
    logic [`LOAD_LOG2_PREFETCH:0] fifo_count;

    load_request_ctrl u_request (
        .clk, .internal_reset,
        .req_start, .cfg,
        .dma_idle, .dma_active,
        .dma_cmd_valid, .dma_cmd,
        .line_req_valid, .line_req_burst,
        .rx_valid, .rx_data,
        .fifo_we, .fifo_wdata, .fifo_count
    );

    load_receive_ctrl u_receive (
        .clk, .internal_reset,
        .op_start, .cfg_length(cfg.length), .req_start,
        .fifo_rvalid, .fifo_rdata, .fifo_empty, .fifo_re,
        .out_almost_full, .out_valid, .out_data, .op_done
    );

    prefetch_fifo u_fifo (
        .clk, .internal_reset,
        .we(fifo_we), .wdata(fifo_wdata),
        .re(fifo_re), .rvalid(fifo_rvalid), .rdata(fifo_rdata),
        .empty(fifo_empty), .count(fifo_count)
    );

endmodule

/* verification/load_unit_tb.sv */
`timescale 1ns/1ps
`include "load_defs.svh"

module load_unit_tb;
    import load_pkg::*;

    localparam int TIMEOUT_CYCLES = 3000;

    logic clk;
    logic internal_reset;
    logic op_start;
    load_cfg_t cfg;
    logic op_done;
    logic dma_idle;
    logic dma_active;
    logic dma_cmd_valid;
    dma_cmd_t dma_cmd;
    logic line_req_valid;
    burst_t line_req_burst;
    logic rx_valid;
    line_t rx_data;
    logic out_almost_full;
    logic out_valid;
    line_t out_data;

    integer seed;

    // Scoreboard and DMA model state
    line_addr_t ref_addr;
    int load_length;
    bit no_trigger;
    bit cmd_seen;
    int cmd_count;
    line_addr_t cmd_addr;
    line_count_t cmd_length;
    logic cmd_multiline;
    int requested_lines;
    int pending_lines;
    int sent_lines;
    int burst_log [$];
    line_t expected_q [$];
    int out_count;
    logic out_valid_prev;

    load_unit u_dut (
        .clk, .internal_reset,
        .op_start, .cfg, .op_done,
        .dma_idle, .dma_active,
        .dma_cmd_valid, .dma_cmd,
        .line_req_valid, .line_req_burst,
        .rx_valid, .rx_data,
        .out_almost_full, .out_valid, .out_data
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // **************************************************
    // Reference model
    // **************************************************
    function automatic line_addr_t expected_addr(input load_cfg_t c);
        return c.base_addr + line_addr_t'(c.offset0) + line_addr_t'(c.offset1)
               + line_addr_t'(c.offset2);
    endfunction

    // Line payload is address plus index, repeated over the width
    function automatic line_t expected_line(input line_addr_t addr, input int index);
        logic [63:0] word;
        word = 64'(addr) + 64'(index);
        return {(`LOAD_LINE_WIDTH / 64){word}};
    endfunction

    // Lines in burst number index, 0 past the last burst
    function automatic int expected_bursts(input int length, input bit multiline,
                                           input int index);
        int requested;
        int lines;
        int n;
        requested = 0;
        lines = 0;
        for (n = 0; n <= index; n++)
        begin
            if (multiline && requested + 4 < length)
                lines = 4;
            else if (multiline && requested + 2 < length)
                lines = 2;
            else if (requested < length)
                lines = 1;
            else
                lines = 0;
            requested += lines;
        end
        return lines;
    endfunction

    function automatic int lines_of_code(input burst_t code);
        case (code)
            `LOAD_BURST_1: return 1;
            `LOAD_BURST_2: return 2;
            `LOAD_BURST_4: return 4;
            default: return 0;
        endcase
    endfunction

    function automatic load_cfg_t make_cfg(input line_addr_t base, input int o0, input int o1,
                                           input int o2, input int len, input bit ml,
                                           input bit trig);
        load_cfg_t c;
        c.base_addr = base;
        c.offset0 = line_count_t'(o0);
        c.offset1 = line_count_t'(o1);
        c.offset2 = line_count_t'(o2);
        c.length = line_count_t'(len);
        c.multiline = ml;
        c.trigger_dma = trig;
        return c;
    endfunction

    task automatic check_value(input string name, input line_t actual, input line_t expected);
        if (actual !== expected)
        begin
            $display("mismatch at %0t: %s actual %0h expected %0h",
                     $time, name, actual, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic fail_with(input string what);
        $display("%0t: %s", $time, what);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped");
    endtask

    // **************************************************
    // DMA responder
    // **************************************************
    initial
    begin : dma_responder
        int lines;
        int gap;
        logic idle_prev;
        logic [31:0] draw;
        dma_active <= 1'b0;
        rx_valid <= 1'b0;
        rx_data <= '0;
        gap = 0;
        idle_prev = 1'b0;
        forever
        begin
            @(posedge clk);
            rx_valid <= 1'b0;
            if (dma_cmd_valid)
            begin
                // Command must follow an idle DMA
                check_value("dma_idle before dma_cmd_valid", line_t'(idle_prev), line_t'(1));
                cmd_count++;
                cmd_addr = dma_cmd.addr;
                cmd_length = dma_cmd.length;
                cmd_multiline = dma_cmd.multiline;
                cmd_seen = 1'b1;
            end
            dma_active <= cmd_seen || no_trigger;
            if (line_req_valid)
            begin
                lines = lines_of_code(line_req_burst);
                if (lines == 0)
                    fail_with("line request carried an unknown burst code");
                burst_log.push_back(lines);
                requested_lines += lines;
                pending_lines += lines;
            end
            if (pending_lines > 0 && gap == 0)
            begin
                rx_valid <= 1'b1;
                rx_data <= expected_line(ref_addr, sent_lines);
                sent_lines++;
                pending_lines--;
                draw = $random(seed);
                gap = int'(draw[1:0]);
            end
            else if (gap > 0)
            begin
                gap--;
            end
            idle_prev = dma_idle;
        end
    end

    // Compare process for the output stream
    always @(posedge clk)
    begin
        if (out_valid)
        begin
            if (expected_q.size() == 0)
                fail_with("output line appeared with no line expected");
            check_value("out_data", out_data, expected_q.pop_front());
            out_count++;
        end
        if (op_done && load_length != 0)
            check_value("out_valid before op_done", line_t'(out_valid_prev), line_t'(1));
        out_valid_prev = out_valid;
    end

    // **************************************************
    // Stimulus
    // **************************************************
    task automatic run_load(input load_cfg_t c, input bit backpressure, input int idle_delay);
        int cycles;
        int idle_left;
        int i;
        bit done;
        logic [31:0] draw;
        ref_addr = expected_addr(c);
        load_length = int'(c.length);
        cmd_count = 0;
        cmd_seen = 1'b0;
        no_trigger = !c.trigger_dma;
        requested_lines = 0;
        pending_lines = 0;
        sent_lines = 0;
        out_count = 0;
        burst_log.delete();
        expected_q.delete();
        for (i = 0; i < load_length; i++)
            expected_q.push_back(expected_line(ref_addr, i));
        if (idle_delay > 0)
            dma_idle <= 1'b0;
        cfg <= c;
        op_start <= 1'b1;
        @(posedge clk);
        op_start <= 1'b0;
        cycles = 0;
        idle_left = idle_delay;
        done = 1'b0;
        while (!done)
        begin
            @(posedge clk);
            cycles++;
            if (backpressure)
            begin
                // Consumer stalls three cycles in four, so the FIFO fills up
                draw = $random(seed);
                out_almost_full <= (draw[1:0] != 2'b00);
            end
            if (idle_left > 0)
            begin
                idle_left--;
                if (idle_left == 0)
                    dma_idle <= 1'b1;
            end
            done = op_done;
            if (cycles > TIMEOUT_CYCLES)
                fail_with("timeout while waiting for op_done");
        end
        out_almost_full <= 1'b0;
        if (load_length == 0)
            check_value("op_done latency", line_t'(cycles), line_t'(2));
        check_value("lines forwarded", line_t'(out_count), line_t'(load_length));
        check_value("lines requested", line_t'(requested_lines), line_t'(load_length));
        for (i = 0; i < burst_log.size(); i++)
            check_value("line_req_burst", line_t'(burst_log[i]),
                        line_t'(expected_bursts(load_length, c.multiline, i)));
        check_value("missing bursts", line_t'(expected_bursts(load_length, c.multiline,
                    burst_log.size())), line_t'(0));
        check_value("dma_cmd_valid count", line_t'(cmd_count),
                    line_t'(c.trigger_dma && load_length != 0));
        if (cmd_count != 0)
        begin
            check_value("dma_cmd.addr", line_t'(cmd_addr), line_t'(ref_addr));
            check_value("dma_cmd.length", line_t'(cmd_length), line_t'(c.length));
            check_value("dma_cmd.multiline", line_t'(cmd_multiline), line_t'(c.multiline));
        end
        no_trigger = 1'b0;
        cmd_seen = 1'b0;
        repeat (3) @(posedge clk);
    endtask

    initial
    begin
        logic [31:0] draw;
        seed = 32'h2868_fc9a;
        internal_reset <= 1'b1;
        op_start <= 1'b0;
        cfg <= '0;
        dma_idle <= 1'b1;
        out_almost_full <= 1'b0;
        load_length = 0;
        no_trigger = 1'b0;
        cmd_seen = 1'b0;
        out_count = 0;
        out_valid_prev = 1'b0;
        repeat (5) @(posedge clk);
        internal_reset <= 1'b0;
        repeat (2) @(posedge clk);

        // Empty load, no DMA traffic at all
        run_load(make_cfg(48'h0000_0000_4000, 1, 2, 3, 0, 1'b0, 1'b1), 1'b0, 0);
        // Single-line bursts with offsets
        run_load(make_cfg(48'h0000_0001_0000, 3, 17, 250, 5, 1'b0, 1'b1), 1'b0, 0);
        // Burst mix 4, 4, 2, 1
        run_load(make_cfg(48'h0000_0002_0000, 8, 0, 5, 11, 1'b1, 1'b1), 1'b0, 0);
        // Consumer back-pressure over a long load
        run_load(make_cfg(48'h0000_0003_0000, 40, 9, 1, 40, 1'b1, 1'b1), 1'b1, 0);
        // No DMA command
        run_load(make_cfg(48'h0000_0004_0000, 2, 4, 6, 7, 1'b1, 1'b0), 1'b0, 0);
        // DMA busy for a while before the command
        draw = $random(seed);
        run_load(make_cfg(48'h0000_0005_0000, 11, 22, 33, 6, 1'b0, 1'b1), 1'b0,
                 8 + int'(draw[4:0]));

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* load_unit.f */
+incdir+include
hdl/load_pkg.sv
hdl/prefetch_fifo.sv
hdl/load_request_ctrl.sv
hdl/load_receive_ctrl.sv
hdl/load_unit.sv
verification/load_unit_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing
TOP       = load_unit_tb
RTL_TOP   = load_unit
FILELIST  = load_unit.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation finished: FAIL
PASS_MSG  = Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(FLAGS) --binary -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
